// File: cpu_consts.svh
/* core-wide constants: data width, register count, reset pc, bus address width */
`ifndef CPU_CONSTS_SVH
`define CPU_CONSTS_SVH

// data word width
`define CPU_XLEN 32

// architectural registers, x0 included
`define CPU_REG_CNT 32

// first fetch address after reset
`define CPU_RESET_PC 32'h0000_0000

// address bits decoded on the external bus
`define CPU_MEM_AW 18

`endif

// File: cpu_isa_pkg.sv
/* instruction set types: major opcodes, ALU operations, branch kinds */
`default_nettype none

package cpu_isa_pkg;

	// major opcodes handled by the core
	typedef enum logic [6:0] {
		OPC_OP     = 7'b0110011,
		OPC_OP_IMM = 7'b0010011,
		OPC_LUI    = 7'b0110111,
		OPC_JAL    = 7'b1101111,
		OPC_BRANCH = 7'b1100011,
		OPC_LOAD   = 7'b0000011,
		OPC_STORE  = 7'b0100011
	} opcode_e;

	typedef enum logic [3:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_XOR,
		ALU_SLT,
		ALU_SLL,
		ALU_SRL,
		ALU_PASS_B
	} alu_op_e;

	// jump counts as an always-taken branch
	typedef enum logic [1:0] {
		BR_NONE,
		BR_EQ,
		BR_NE,
		BR_JUMP
	} br_kind_e;

endpackage

`default_nettype wire

// File: cpu_pipe_pkg.sv
/* structs passed between pipeline stages and to the memory controller */
`default_nettype none
`include "cpu_consts.svh"

package cpu_pipe_pkg;

	typedef struct packed {
		logic                 valid;
		logic [`CPU_XLEN-1:0] pc;
		logic [31:0]          instr;
	} if_id_t;

	typedef struct packed {
		logic                  valid;
		logic [`CPU_XLEN-1:0]  pc;
		cpu_isa_pkg::alu_op_e  alu_op;
		cpu_isa_pkg::br_kind_e br;
		logic [`CPU_XLEN-1:0]  op_a;
		logic [`CPU_XLEN-1:0]  op_b;
		logic [`CPU_XLEN-1:0]  store_data;
		logic [`CPU_XLEN-1:0]  imm;
		logic [4:0]            rd;
		logic                  we;
		logic                  load;
		logic                  store;
	} id_ex_t;

	// result doubles as the word address for loads and stores
	typedef struct packed {
		logic                 valid;
		logic [`CPU_XLEN-1:0] result;
		logic [`CPU_XLEN-1:0] store_data;
		logic [4:0]           rd;
		logic                 we;
		logic                 load;
		logic                 store;
	} ex_mem_t;

	typedef struct packed {
		logic                 we;
		logic [4:0]           rd;
		logic [`CPU_XLEN-1:0] data;
	} wb_t;

	// destination still owned by a later stage
	typedef struct packed {
		logic       we;
		logic [4:0] rd;
	} dst_t;

	typedef struct packed {
		logic                 taken;
		logic [`CPU_XLEN-1:0] target;
	} redirect_t;

	typedef struct packed {
		logic        valid;
		logic        write;
		logic [31:0] addr;
		logic [7:0]  wdata;
	} bus_req_t;

endpackage

`default_nettype wire

// File: fetch_stage.sv
/* instruction fetch: pc, byte-serial word assembly, branch redirect */
`timescale 1ns/1ps
`default_nettype none
`include "cpu_consts.svh"

module fetch_stage (
	input  logic                    clk_in,
	input  logic                    rst_i,
	input  logic                    run_i,
	input  cpu_pipe_pkg::redirect_t redirect_i,
	input  logic                    grant_i,
	input  logic                    rvalid_i,
	input  logic [7:0]              rdata_i,
	input  logic                    id_ready_i,
	output cpu_pipe_pkg::bus_req_t  req_o,
	output cpu_pipe_pkg::if_id_t    if_id_o
);

	logic [31:0] pc_q;
	logic [31:0] word_q;
	logic [2:0]  issued_q;
	logic [1:0]  rcv_q;
	logic        valid_q;

	// stop asking once four reads are out or a word waits for decode
	assign req_o = '{
		valid: !valid_q && issued_q != 3'd4 && !redirect_i.taken,
		write: 1'b0,
		addr:  pc_q + {29'd0, issued_q},
		wdata: 8'h00
	};

	assign if_id_o = '{valid: valid_q, pc: pc_q, instr: word_q};

	always_ff @(posedge clk_in) begin
		if (rst_i) begin
			pc_q     <= `CPU_RESET_PC;
			issued_q <= 3'd0;
			rcv_q    <= 2'd0;
			valid_q  <= 1'b0;
		end else begin
			// returned bytes land even while the core is paused
			if (rvalid_i) begin
				word_q <= {rdata_i, word_q[31:8]};
				rcv_q  <= rcv_q + 2'd1;
				if (rcv_q == 2'd3)
					valid_q <= 1'b1;
			end
			if (run_i) begin
				if (redirect_i.taken) begin
					pc_q     <= redirect_i.target;
					issued_q <= 3'd0;
					rcv_q    <= 2'd0;
					valid_q  <= 1'b0;
				end else if (valid_q && id_ready_i) begin
					pc_q     <= pc_q + 32'd4;
					issued_q <= 3'd0;
					valid_q  <= 1'b0;
				end else if (grant_i) begin
					issued_q <= issued_q + 3'd1;
				end
			end
		end
	end

endmodule

`default_nettype wire

// File: decode_stage.sv
/* instruction decode: immediates, control mapping, register reads, hazard interlock */
`timescale 1ns/1ps
`default_nettype none

module decode_stage (
	input  logic                    clk_in,
	input  logic                    rst_i,
	input  logic                    run_i,
	input  cpu_pipe_pkg::redirect_t redirect_i,
	input  cpu_pipe_pkg::if_id_t    if_id_i,
	output logic                    id_ready_o,
	input  logic                    ex_ready_i,
	output logic [4:0]              raddr1_o,
	output logic [4:0]              raddr2_o,
	input  logic [31:0]             rdata1_i,
	input  logic [31:0]             rdata2_i,
	input  cpu_pipe_pkg::dst_t      ex_busy_i,
	input  cpu_pipe_pkg::dst_t      mem_busy_i,
	output cpu_pipe_pkg::id_ex_t    id_ex_o
);

	cpu_pipe_pkg::id_ex_t q, dec;
	logic [31:0] in, imm_i, imm_s, imm_b, imm_u, imm_j;
	logic [2:0]  f3;
	logic        use1, use2, hazard;

	function automatic cpu_isa_pkg::alu_op_e alu_sel(input logic [2:0] fn, input logic alt);
		case (fn)
			3'b000:  alu_sel = alt ? cpu_isa_pkg::ALU_SUB : cpu_isa_pkg::ALU_ADD;
			3'b001:  alu_sel = cpu_isa_pkg::ALU_SLL;
			3'b010:  alu_sel = cpu_isa_pkg::ALU_SLT;
			3'b100:  alu_sel = cpu_isa_pkg::ALU_XOR;
			3'b101:  alu_sel = cpu_isa_pkg::ALU_SRL;
			3'b110:  alu_sel = cpu_isa_pkg::ALU_OR;
			default: alu_sel = cpu_isa_pkg::ALU_AND;
		endcase
	endfunction

	function automatic logic busy(input cpu_pipe_pkg::dst_t d, input logic [4:0] r);
		busy = d.we && d.rd == r;
	endfunction

	assign in    = if_id_i.instr;
	assign f3    = in[14:12];
	assign imm_i = {{20{in[31]}}, in[31:20]};
	assign imm_s = {{20{in[31]}}, in[31:25], in[11:7]};
	assign imm_b = {{19{in[31]}}, in[31], in[7], in[30:25], in[11:8], 1'b0};
	assign imm_u = {in[31:12], 12'd0};
	assign imm_j = {{11{in[31]}}, in[31], in[19:12], in[20], in[30:21], 1'b0};

	assign raddr1_o = in[19:15];
	assign raddr2_o = in[24:20];

	always_comb begin
		dec = '{valid: 1'b1, pc: if_id_i.pc, alu_op: cpu_isa_pkg::ALU_ADD,
			br: cpu_isa_pkg::BR_NONE, op_a: rdata1_i, op_b: rdata2_i,
			store_data: rdata2_i, imm: 32'd0, rd: in[11:7],
			we: 1'b0, load: 1'b0, store: 1'b0};
		use1 = 1'b0;
		use2 = 1'b0;
		case (in[6:0])
			cpu_isa_pkg::OPC_OP, cpu_isa_pkg::OPC_OP_IMM: begin
				dec.alu_op = alu_sel(f3, in[5] && in[30]);
				// sltu and sra forms fall through as no-ops
				dec.we = f3 != 3'b011 && !(f3 == 3'b101 && in[30]);
				use1   = 1'b1;
				use2   = in[5];
				if (!in[5])
					dec.op_b = imm_i;
			end
			cpu_isa_pkg::OPC_LUI: begin
				dec.alu_op = cpu_isa_pkg::ALU_PASS_B;
				dec.op_b   = imm_u;
				dec.we     = 1'b1;
			end
			cpu_isa_pkg::OPC_JAL: begin
				dec.br  = cpu_isa_pkg::BR_JUMP;
				dec.imm = imm_j;
				dec.we  = 1'b1;
			end
			cpu_isa_pkg::OPC_BRANCH: begin
				if (f3 == 3'b000)
					dec.br = cpu_isa_pkg::BR_EQ;
				else if (f3 == 3'b001)
					dec.br = cpu_isa_pkg::BR_NE;
				dec.imm = imm_b;
				use1    = 1'b1;
				use2    = 1'b1;
			end
			cpu_isa_pkg::OPC_LOAD: begin
				dec.load = f3 == 3'b010;
				dec.we   = f3 == 3'b010;
				dec.imm  = imm_i;
				use1     = 1'b1;
			end
			cpu_isa_pkg::OPC_STORE: begin
				dec.store = f3 == 3'b010;
				dec.imm   = imm_s;
				use1      = 1'b1;
				use2      = 1'b1;
			end
			default: ;
		endcase
	end

	// own output register, execute result register, memory stage
	always_comb begin
		hazard = 1'b0;
		if (use1 && raddr1_o != 5'd0)
			hazard = (q.valid && q.we && q.rd == raddr1_o) ||
				busy(ex_busy_i, raddr1_o) || busy(mem_busy_i, raddr1_o);
		if (use2 && raddr2_o != 5'd0)
			hazard = hazard || (q.valid && q.we && q.rd == raddr2_o) ||
				busy(ex_busy_i, raddr2_o) || busy(mem_busy_i, raddr2_o);
	end

	assign id_ready_o = !redirect_i.taken && !hazard && (!q.valid || ex_ready_i);
	assign id_ex_o    = q;

	always_ff @(posedge clk_in) begin
		if (rst_i) begin
			q.valid <= 1'b0;
		end else if (run_i && (!q.valid || ex_ready_i)) begin
			q       <= dec;
			q.valid <= if_id_i.valid && id_ready_o;
		end
	end

endmodule

`default_nettype wire

// File: regfile.sv
/* integer register file with x0 tied to zero and write-through reads */
`timescale 1ns/1ps
`default_nettype none
`include "cpu_consts.svh"

module regfile (
	input  logic                 clk_in,
	input  logic                 rst_i,
	input  logic [4:0]           raddr1_i,
	input  logic [4:0]           raddr2_i,
	output logic [`CPU_XLEN-1:0] rdata1_o,
	output logic [`CPU_XLEN-1:0] rdata2_o,
	input  cpu_pipe_pkg::wb_t    wb_i
);

	logic [`CPU_XLEN-1:0] regs [`CPU_REG_CNT];
	logic                 wr_en;

	assign wr_en = wb_i.we && wb_i.rd != 5'd0;

	// writeback in this cycle is visible to decode right away
	assign rdata1_o = (wr_en && wb_i.rd == raddr1_i) ? wb_i.data : regs[raddr1_i];
	assign rdata2_o = (wr_en && wb_i.rd == raddr2_i) ? wb_i.data : regs[raddr2_i];

	always_ff @(posedge clk_in) begin
		if (rst_i) begin
			for (int i = 0; i < `CPU_REG_CNT; i++)
				regs[i] <= '0;
		end else if (wr_en) begin
			regs[wb_i.rd] <= wb_i.data;
		end
	end

endmodule

`default_nettype wire

// File: execute_stage.sv
/* execute: ALU, branch and jump resolution, load/store address generation */
`timescale 1ns/1ps
`default_nettype none

module execute_stage (
	input  logic                    clk_in,
	input  logic                    rst_i,
	input  logic                    run_i,
	input  cpu_pipe_pkg::id_ex_t    id_ex_i,
	output logic                    ex_ready_o,
	input  logic                    mem_ready_i,
	output cpu_pipe_pkg::redirect_t redirect_o,
	output cpu_pipe_pkg::ex_mem_t   ex_mem_o,
	output cpu_pipe_pkg::dst_t      ex_busy_o
);

	cpu_pipe_pkg::ex_mem_t q;
	logic [31:0] a, b, alu_res, result;
	logic        eq;

	assign a  = id_ex_i.op_a;
	assign b  = id_ex_i.op_b;
	assign eq = a == b;

	always_comb begin
		case (id_ex_i.alu_op)
			cpu_isa_pkg::ALU_SUB:    alu_res = a - b;
			cpu_isa_pkg::ALU_AND:    alu_res = a & b;
			cpu_isa_pkg::ALU_OR:     alu_res = a | b;
			cpu_isa_pkg::ALU_XOR:    alu_res = a ^ b;
			cpu_isa_pkg::ALU_SLT:    alu_res = {31'd0, $signed(a) < $signed(b)};
			cpu_isa_pkg::ALU_SLL:    alu_res = a << b[4:0];
			cpu_isa_pkg::ALU_SRL:    alu_res = a >> b[4:0];
			cpu_isa_pkg::ALU_PASS_B: alu_res = b;
			default:                 alu_res = a + b;
		endcase
	end

	// jal links pc+4, memory ops carry their address
	always_comb begin
		if (id_ex_i.br == cpu_isa_pkg::BR_JUMP)
			result = id_ex_i.pc + 32'd4;
		else if (id_ex_i.load || id_ex_i.store)
			result = a + id_ex_i.imm;
		else
			result = alu_res;
	end

	assign redirect_o = '{
		taken:  id_ex_i.valid && (id_ex_i.br == cpu_isa_pkg::BR_JUMP ||
			(id_ex_i.br == cpu_isa_pkg::BR_EQ && eq) ||
			(id_ex_i.br == cpu_isa_pkg::BR_NE && !eq)),
		target: id_ex_i.pc + id_ex_i.imm
	};

	assign ex_ready_o = !q.valid || mem_ready_i;
	assign ex_mem_o   = q;
	assign ex_busy_o  = '{we: q.valid && q.we, rd: q.rd};

	always_ff @(posedge clk_in) begin
		if (rst_i) begin
			q.valid <= 1'b0;
		end else if (run_i && ex_ready_o) begin
			q <= '{valid: id_ex_i.valid, result: result, store_data: id_ex_i.store_data,
				rd: id_ex_i.rd, we: id_ex_i.we, load: id_ex_i.load, store: id_ex_i.store};
		end
	end

endmodule

`default_nettype wire

// File: mem_stage.sv
/* memory stage: byte-serial word loads and stores, register writeback */
`timescale 1ns/1ps
`default_nettype none

module mem_stage (
	input  logic                   clk_in,
	input  logic                   rst_i,
	input  logic                   run_i,
	input  cpu_pipe_pkg::ex_mem_t  ex_mem_i,
	output logic                   mem_ready_o,
	input  logic                   grant_i,
	input  logic                   rvalid_i,
	input  logic [7:0]             rdata_i,
	output cpu_pipe_pkg::bus_req_t req_o,
	output cpu_pipe_pkg::wb_t      wb_o,
	output cpu_pipe_pkg::dst_t     mem_busy_o
);

	cpu_pipe_pkg::ex_mem_t mq;
	logic [31:0] word_q, ld_word;
	logic [2:0]  issued_q;
	logic [1:0]  rcv_q;
	logic        full_q, done;

	// last byte may arrive this cycle or have arrived during a pause
	assign ld_word = full_q ? word_q : {rdata_i, word_q[31:8]};

	always_comb begin
		if (!mq.valid)
			done = 1'b0;
		else if (mq.load)
			done = full_q || (rvalid_i && rcv_q == 2'd3);
		else if (mq.store)
			done = grant_i && issued_q == 3'd3;
		else
			done = 1'b1;
	end

	assign mem_ready_o = !mq.valid || done;

	assign req_o = '{
		valid: mq.valid && (mq.load || mq.store) && issued_q != 3'd4,
		write: mq.store,
		addr:  mq.result + {29'd0, issued_q},
		wdata: mq.store_data[issued_q[1:0]*8 +: 8]
	};

	assign wb_o       = '{we: run_i && done && mq.we, rd: mq.rd,
		data: mq.load ? ld_word : mq.result};
	assign mem_busy_o = '{we: mq.valid && mq.we && !wb_o.we, rd: mq.rd};

	always_ff @(posedge clk_in) begin
		if (rst_i) begin
			mq.valid <= 1'b0;
			issued_q <= 3'd0;
			rcv_q    <= 2'd0;
			full_q   <= 1'b0;
		end else begin
			if (rvalid_i) begin
				word_q <= ld_word;
				rcv_q  <= rcv_q + 2'd1;
				if (rcv_q == 2'd3)
					full_q <= 1'b1;
			end
			if (run_i) begin
				if (mem_ready_o) begin
					mq       <= ex_mem_i;
					issued_q <= 3'd0;
					full_q   <= 1'b0;
				end else if (grant_i) begin
					issued_q <= issued_q + 3'd1;
				end
			end
		end
	end

endmodule

`default_nettype wire

// File: mem_ctrl.sv
/* memory bus arbiter: memory stage over fetch, read return routing, pause */
`timescale 1ns/1ps
`default_nettype none
`include "cpu_consts.svh"

module mem_ctrl (
	input  logic                   clk_in,
	input  logic                   rst_i,
	input  logic                   rdy_i,
	input  cpu_pipe_pkg::bus_req_t if_req_i,
	input  cpu_pipe_pkg::bus_req_t mem_req_i,
	output logic                   if_grant_o,
	output logic                   mem_grant_o,
	output logic                   if_rvalid_o,
	output logic                   mem_rvalid_o,
	output logic [7:0]             rdata_o,
	output logic                   run_o,
	input  logic [7:0]             mem_din_i,
	output logic [7:0]             mem_dout_o,
	output logic [31:0]            mem_a_o,
	output logic                   mem_wr_o
);

	logic [31:0] addr;

	assign run_o       = rdy_i;
	assign mem_grant_o = rdy_i && mem_req_i.valid;
	assign if_grant_o  = rdy_i && if_req_i.valid && !mem_req_i.valid;

	assign addr       = mem_grant_o ? mem_req_i.addr : (if_grant_o ? if_req_i.addr : 32'd0);
	assign mem_a_o    = {{(32-`CPU_MEM_AW){1'b0}}, addr[`CPU_MEM_AW-1:0]};
	assign mem_wr_o   = mem_grant_o && mem_req_i.write;
	assign mem_dout_o = mem_wr_o ? mem_req_i.wdata : 8'h00;
	assign rdata_o    = mem_din_i;

	// owner of the read issued last cycle
	always_ff @(posedge clk_in) begin
		if (rst_i) begin
			if_rvalid_o  <= 1'b0;
			mem_rvalid_o <= 1'b0;
		end else begin
			if_rvalid_o  <= if_grant_o;
			mem_rvalid_o <= mem_grant_o && !mem_req_i.write;
		end
	end

endmodule

`default_nettype wire

// File: cpu.sv
/* core top level: pipeline stages, register file and bus controller */
`timescale 1ns/1ps
`default_nettype none

module cpu (
	input  logic        clk_in,
	input  logic        rst_i,
	input  logic        rdy_i,
	input  logic [7:0]  mem_din_i,
	output logic [7:0]  mem_dout_o,
	output logic [31:0] mem_a_o,
	output logic        mem_wr_o
);

	cpu_pipe_pkg::if_id_t    if_id;
	cpu_pipe_pkg::id_ex_t    id_ex;
	cpu_pipe_pkg::ex_mem_t   ex_mem;
	cpu_pipe_pkg::wb_t       wb;
	cpu_pipe_pkg::redirect_t redirect;
	cpu_pipe_pkg::bus_req_t  if_req, mem_req;
	cpu_pipe_pkg::dst_t      ex_busy, mem_busy;
	logic [4:0]  raddr1, raddr2;
	logic [31:0] rdata1, rdata2;
	logic [7:0]  rdata;
	logic        run, id_ready, ex_ready, mem_ready;
	logic        if_grant, mem_grant, if_rvalid, mem_rvalid;

	fetch_stage u_fetch (.clk_in, .rst_i, .run_i(run), .redirect_i(redirect),
		.grant_i(if_grant), .rvalid_i(if_rvalid), .rdata_i(rdata),
		.id_ready_i(id_ready), .req_o(if_req), .if_id_o(if_id));

	decode_stage u_decode (.clk_in, .rst_i, .run_i(run), .redirect_i(redirect),
		.if_id_i(if_id), .id_ready_o(id_ready), .ex_ready_i(ex_ready),
		.raddr1_o(raddr1), .raddr2_o(raddr2), .rdata1_i(rdata1), .rdata2_i(rdata2),
		.ex_busy_i(ex_busy), .mem_busy_i(mem_busy), .id_ex_o(id_ex));

	regfile u_regfile (.clk_in, .rst_i, .raddr1_i(raddr1), .raddr2_i(raddr2),
		.rdata1_o(rdata1), .rdata2_o(rdata2), .wb_i(wb));

	execute_stage u_execute (.clk_in, .rst_i, .run_i(run), .id_ex_i(id_ex),
		.ex_ready_o(ex_ready), .mem_ready_i(mem_ready), .redirect_o(redirect),
		.ex_mem_o(ex_mem), .ex_busy_o(ex_busy));

	mem_stage u_mem (.clk_in, .rst_i, .run_i(run), .ex_mem_i(ex_mem),
		.mem_ready_o(mem_ready), .grant_i(mem_grant), .rvalid_i(mem_rvalid),
		.rdata_i(rdata), .req_o(mem_req), .wb_o(wb), .mem_busy_o(mem_busy));

	mem_ctrl u_mem_ctrl (.clk_in, .rst_i, .rdy_i, .if_req_i(if_req), .mem_req_i(mem_req),
		.if_grant_o(if_grant), .mem_grant_o(mem_grant), .if_rvalid_o(if_rvalid),
		.mem_rvalid_o(mem_rvalid), .rdata_o(rdata), .run_o(run), .mem_din_i,
		.mem_dout_o, .mem_a_o, .mem_wr_o);

endmodule

`default_nettype wire

// File: tb_cpu.sv
/* testbench for the cpu core: clock, reset, byte memory, program builder,
   reference model, store checks and watchdog */
`timescale 1ns/1ps
`default_nettype none
`include "cpu_consts.svh"

module tb_cpu;

	localparam int          MEM_BYTES = 1 << `CPU_MEM_AW;
	localparam logic [31:0] DATA_BASE = 32'h0001_0000;

	logic        clk_in;
	logic        rst_i;
	logic        rdy_i;
	logic [7:0]  mem_din_i;
	logic [7:0]  mem_dout_o;
	logic [31:0] mem_a_o;
	logic        mem_wr_o;

	logic [7:0]  mem [MEM_BYTES];
	logic [7:0]  rd_byte;
	logic [31:0] prog [$];
	logic [31:0] exp_addr [$];
	logic [31:0] exp_data [$];
	logic [31:0] saved_prog [$];
	logic [31:0] saved_addr [$];
	logic [31:0] saved_data [$];
	logic [31:0] model [32];
	logic [31:0] dmem_model [int];
	logic [31:0] rng;
	logic [31:0] wr_base;
	logic [31:0] wr_word;
	int          nbytes;
	int          next_off;
	int          last_off;
	int          wd_cnt;
	int          wd_limit;
	bit          pause_en;
	string       cur_test;

	cpu dut (.clk_in, .rst_i, .rdy_i, .mem_din_i, .mem_dout_o, .mem_a_o, .mem_wr_o);

	always #5 clk_in = ~clk_in;

	task automatic abort_run(input string reason);
		$display("%s", reason);
		$display("Some tests failed");
		$fatal(1);
	endtask

	task automatic report_mismatch(input string what, input logic [31:0] exp, input logic [31:0] act);
		abort_run($sformatf("Fail %s %s: expected %h, actual %h", cur_test, what, exp, act));
	endtask

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		xorshift = y ^ (y << 5);
	endfunction

	function automatic logic [31:0] rand_word();
		rng = xorshift(rng);
		rand_word = rng;
	endfunction

	// RV32I result for funct3 plus the bit-30 alternate form
	function automatic logic [31:0] alu_model(input logic [2:0] f3, input logic alt,
		input logic [31:0] a, input logic [31:0] b);
		case (f3)
			3'd0:    alu_model = alt ? a - b : a + b;
			3'd1:    alu_model = a << b[4:0];
			3'd2:    alu_model = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
			3'd4:    alu_model = a ^ b;
			3'd5:    alu_model = a >> b[4:0];
			3'd6:    alu_model = a | b;
			default: alu_model = a & b;
		endcase
	endfunction

	task automatic put_reg(input int rd, input logic [31:0] v);
		if (rd != 0)
			model[rd] = v;
	endtask

	// lui then addi with the upper part rounded for the sign of the low half
	task automatic load_imm(input int rd, input logic [31:0] v);
		logic [19:0] hi;
		hi = v[31:12] + {19'd0, v[11]};
		prog.push_back({hi, 5'(rd), 7'b0110111});
		prog.push_back({v[11:0], 5'(rd), 3'b000, 5'(rd), 7'b0010011});
		put_reg(rd, v);
	endtask

	task automatic op_reg(input logic [2:0] f3, input logic alt, input int rd, input int rs1,
		input int rs2);
		prog.push_back({1'b0, alt, 5'd0, 5'(rs2), 5'(rs1), f3, 5'(rd), 7'b0110011});
		put_reg(rd, alu_model(f3, alt, model[rs1], model[rs2]));
	endtask

	task automatic op_imm(input logic [2:0] f3, input int rd, input int rs1, input logic [11:0] imm);
		prog.push_back({imm, 5'(rs1), f3, 5'(rd), 7'b0010011});
		put_reg(rd, alu_model(f3, 1'b0, model[rs1], {{20{imm[11]}}, imm}));
	endtask

	// next data slot off x31; a skipped store must never reach the bus
	task automatic store_word(input int rs, input bit expected);
		logic [11:0] off;
		off = 12'(next_off);
		prog.push_back({off[11:5], 5'(rs), 5'd31, 3'b010, off[4:0], 7'b0100011});
		if (expected) begin
			exp_addr.push_back(DATA_BASE + next_off);
			exp_data.push_back(model[rs]);
			dmem_model[next_off] = model[rs];
		end
		last_off = next_off;
		next_off += 4;
	endtask

	task automatic load_word(input int rd, input int off);
		prog.push_back({12'(off), 5'd31, 3'b010, 5'(rd), 7'b0000011});
		put_reg(rd, dmem_model[off]);
	endtask

	// skip counts the instructions jumped over
	task automatic branch(input logic [2:0] f3, input int rs1, input int rs2, input int skip);
		logic [12:0] imm;
		imm = 13'((skip + 1) * 4);
		prog.push_back({imm[12], imm[10:5], 5'(rs2), 5'(rs1), f3, imm[4:1], imm[11], 7'b1100011});
	endtask

	task automatic jump(input int rd, input int skip);
		logic [20:0] imm;
		imm = 21'((skip + 1) * 4);
		put_reg(rd, 32'(prog.size() * 4 + 4));
		prog.push_back({imm[20], imm[10:1], imm[11], imm[19:12], 5'(rd), 7'b1101111});
	endtask

	task automatic start_program();
		prog.delete();
		exp_addr.delete();
		exp_data.delete();
		next_off = 0;
		for (int i = 0; i < 32; i++)
			model[i] = 32'd0;
		load_imm(31, DATA_BASE);
	endtask

	task automatic run_test(input string name, input bit pause);
		cur_test = name;
		@(posedge clk_in);
		pause_en = pause;
		#1;
		rst_i    = 1'b1;
		nbytes   = 0;
		wd_limit = prog.size() * 400 + 1000;
		for (int i = 0; i < prog.size(); i++)
			for (int k = 0; k < 4; k++)
				mem[4 * i + k] = prog[i][8 * k +: 8];
		repeat (2) @(posedge clk_in);
		#1;
		rst_i = 1'b0;
		@(negedge clk_in);
		assert (mem_a_o == `CPU_RESET_PC) else report_mismatch("first address", 32'd0, mem_a_o);
		assert (!mem_wr_o) else abort_run({name, ": bus write right after reset"});
		while (exp_addr.size() != 0)
			@(posedge clk_in);
	endtask

	// memory answers one cycle after the address and inputs move 1 ns after the edge
	always @(posedge clk_in) begin
		#1;
		mem_din_i = rd_byte;
		if (pause_en) begin
			rng   = xorshift(rng);
			rdy_i = rng[1:0] != 2'd0;
		end else begin
			rdy_i = 1'b1;
		end
	end

	// bus sampled mid-cycle and every four written bytes form one stored word
	always @(negedge clk_in) begin
		if (!rst_i) begin
			assert (rdy_i || !mem_wr_o) else abort_run({cur_test, ": bus write while rdy_i low"});
			if (mem_wr_o) begin
				mem[mem_a_o[`CPU_MEM_AW-1:0]] = mem_dout_o;
				if (nbytes == 0)
					wr_base = mem_a_o;
				else
					assert (mem_a_o == wr_base + nbytes)
						else report_mismatch("byte address", wr_base + nbytes, mem_a_o);
				wr_word[8 * nbytes +: 8] = mem_dout_o;
				nbytes++;
				if (nbytes == 4) begin
					nbytes = 0;
					if (exp_addr.size() == 0) begin
						abort_run($sformatf("%s: unexpected store to %h", cur_test, wr_base));
					end else begin
						assert (wr_base == exp_addr[0])
							else report_mismatch("store address", exp_addr[0], wr_base);
						assert (wr_word == exp_data[0])
							else report_mismatch("store data", exp_data[0], wr_word);
						void'(exp_addr.pop_front());
						void'(exp_data.pop_front());
					end
				end
			end
			rd_byte = mem[mem_a_o[`CPU_MEM_AW-1:0]];
		end
	end

	always @(posedge clk_in) begin
		if (rst_i) begin
			wd_cnt = 0;
		end else begin
			wd_cnt++;
			if (wd_cnt > wd_limit)
				abort_run($sformatf("%s: timed out after %0d cycles", cur_test, wd_limit));
		end
	end

	initial begin
		logic [31:0] r;
		clk_in    = 1'b0;
		rst_i     = 1'b1;
		rdy_i     = 1'b1;
		mem_din_i = 8'h00;
		rd_byte   = 8'h00;
		pause_en  = 1'b0;
		nbytes    = 0;
		wd_cnt    = 0;
		wd_limit  = 1000;
		rng       = 32'h8f239fed;
		for (int i = 0; i < MEM_BYTES; i++)
			mem[i] = 8'(i ^ (i >> 8) ^ (i >> 16));

		// every OP and OP_IMM form on random operands
		start_program();
		for (int f = 0; f < 8; f++) begin
			if (f != 3) begin
				load_imm(1, rand_word());
				load_imm(2, rand_word());
				op_reg(3'(f), 1'b0, 3, 1, 2);
				store_word(3, 1);
				if (f == 0) begin
					op_reg(3'd0, 1'b1, 4, 1, 2);
					store_word(4, 1);
				end
				r = rand_word();
				op_imm(3'(f), 5, 1, (f == 1 || f == 5) ? {7'd0, r[4:0]} : r[11:0]);
				store_word(5, 1);
			end
		end
		jump(0, -1);
		saved_prog = prog;
		saved_addr = exp_addr;
		saved_data = exp_data;
		run_test("alu", 1'b0);

		// each instruction reads the one before it
		start_program();
		load_imm(1, rand_word());
		load_imm(2, rand_word());
		r = rand_word();
		op_imm(3'd0, 3, 1, r[11:0]);
		op_reg(3'd0, 1'b0, 4, 3, 2);
		op_reg(3'd4, 1'b0, 5, 4, 1);
		op_reg(3'd0, 1'b1, 6, 5, 4);
		op_imm(3'd1, 7, 6, 12'd3);
		op_reg(3'd6, 1'b0, 8, 7, 3);
		op_reg(3'd5, 1'b0, 9, 8, 2);
		op_reg(3'd2, 1'b0, 10, 9, 6);
		op_reg(3'd7, 1'b0, 11, 10, 8);
		for (int i = 3; i <= 11; i++)
			store_word(i, 1);
		jump(0, -1);
		run_test("chain", 1'b0);

		// taken, not taken, and a linking jump
		start_program();
		r = rand_word();
		load_imm(1, r);
		op_imm(3'd0, 2, 1, 12'd0);
		load_imm(3, r + 32'd1);
		branch(3'b000, 1, 2, 2);
		store_word(1, 0);
		store_word(2, 0);
		store_word(1, 1);
		branch(3'b001, 1, 2, 1);
		store_word(2, 1);
		branch(3'b001, 1, 3, 1);
		store_word(3, 0);
		branch(3'b000, 1, 3, 1);
		store_word(3, 1);
		jump(7, 1);
		store_word(1, 0);
		store_word(7, 1);
		jump(0, -1);
		run_test("branch", 1'b0);

		start_program();
		for (int i = 0; i < 2; i++) begin
			load_imm(1 + 2 * i, rand_word());
			store_word(1 + 2 * i, 1);
			load_word(2 + 2 * i, last_off);
			store_word(2 + 2 * i, 1);
		end
		jump(0, -1);
		run_test("memory", 1'b0);

		prog     = saved_prog;
		exp_addr = saved_addr;
		exp_data = saved_data;
		run_test("pause", 1'b1);

		$display("All tests passed");
		$finish;
	end

endmodule

`default_nettype wire

// File: cpu.f
+incdir+.
cpu_isa_pkg.sv
cpu_pipe_pkg.sv
fetch_stage.sv
decode_stage.sv
regfile.sv
execute_stage.sv
mem_stage.sv
mem_ctrl.sv
cpu.sv
tb_cpu.sv

// File: Bender.yml
package:
  name: cpu

sources:
  - include_dirs:
      - .
    files:
      - cpu_isa_pkg.sv
      - cpu_pipe_pkg.sv
      - fetch_stage.sv
      - decode_stage.sv
      - regfile.sv
      - execute_stage.sv
      - mem_stage.sv
      - mem_ctrl.sv
      - cpu.sv
  - target: simulation
    include_dirs:
      - .
    files:
      - tb_cpu.sv
